// ==== rvcore.f ====
+incdir+logic
logic/rvcore_pkg.sv
logic/rvFetch.sv
logic/rvDecoder.sv
logic/rvExecute.sv
logic/rvRegFile.sv
logic/rvCsrFile.sv
logic/rvCore.sv
bench/rvCore_props.sv
bench/rvCore_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP = rvCore_tb
FILELIST = rvcore.f
OBJDIR = obj_dir
PASS = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// ==== bench/rvCore_tb.sv ====
`timescale 1ns/1ps
`include "rvcore_consts.svh"

module rvCore_tb;
  localparam int NumInsts = 400;
  localparam int Timeout = 50;

  logic clk;
  logic reset;
  logic instValid;
  logic [31:0] inst;
  logic fetchReq;
  logic [31:0] fetchPc;
  rvcore_pkg::retireInfo retire;

  int seed;
  int errorCount = 0;
  int checkCount = 0;
  int retireCount = 0;
  int reqCount = 0;
  int n;
  int waited;
  int latency;
  bit ok;
  logic [1:0] delay;
  logic [31:0] rnd;
  logic [31:0] instWord;
  rvcore_pkg::retireInfo expRetire;

  // reference model state
  logic [31:0] regs [32];
  logic [31:0] csrs [4];
  logic [31:0] modelPc;

  rvCore i_dut (
    .clk      (clk),
    .reset    (reset),
    .instValid(instValid),
    .inst     (inst),
    .fetchReq (fetchReq),
    .fetchPc  (fetchPc),
    .retire   (retire)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(negedge clk) begin
    if (!reset) begin
      if (retire.valid) begin
        retireCount <= retireCount + 1;
      end
      if (fetchReq) begin
        reqCount <= reqCount + 1;
      end
    end
  end

  // csr index 0 mtvec, 1 mepc, 2 mcause, 3 mscratch
  function automatic logic [11:0] csrAddrOf(input logic [1:0] idx);
    case (idx)
      2'd0: csrAddrOf = `CSR_MTVEC;
      2'd1: csrAddrOf = `CSR_MEPC;
      2'd2: csrAddrOf = `CSR_MCAUSE;
      default: csrAddrOf = `CSR_MSCRATCH;
    endcase
  endfunction

  function automatic logic [1:0] csrIndex(input logic [11:0] addr);
    case (addr)
      `CSR_MTVEC: csrIndex = 2'd0;
      `CSR_MEPC: csrIndex = 2'd1;
      `CSR_MCAUSE: csrIndex = 2'd2;
      default: csrIndex = 2'd3;
    endcase
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000: aluRef = alt ? x - y : x + y;
      3'b001: aluRef = x << y[4:0];
      3'b010: aluRef = {31'b0, $signed(x) < $signed(y)};
      3'b011: aluRef = {31'b0, x < y};
      3'b100: aluRef = x ^ y;
      3'b101: begin
        if (alt) begin
          aluRef = $signed(x) >>> y[4:0];
        end else begin
          aluRef = x >> y[4:0];
        end
      end
      3'b110: aluRef = x | y;
      default: aluRef = x & y;
    endcase
  endfunction

  // registers limited to x0..x7, ecall and mret rare
  task automatic makeInst(output logic [31:0] word);
    logic [31:0] r;
    logic [31:0] immR;
    logic [4:0] kind;
    logic [4:0] rdI;
    logic [4:0] rs1I;
    logic [4:0] rs2I;
    logic [2:0] f3;
    logic [1:0] cmd;
    logic [12:0] bOff;
    logic [20:0] jOff;
    begin
      r = $random(seed);
      immR = $random(seed);
      kind = r[31:27];
      rdI = {2'b0, r[2:0]};
      rs1I = {2'b0, r[5:3]};
      rs2I = {2'b0, r[8:6]};
      f3 = r[11:9];
      if (kind < 5'd8) begin
        word = {1'b0, immR[31] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                rs2I, rs1I, f3, rdI, `OP_OP};
      end else if (kind < 5'd16) begin
        if (f3 == 3'b001) begin
          word = {7'b0, immR[24:20], rs1I, f3, rdI, `OP_OP_IMM};
        end else if (f3 == 3'b101) begin
          word = {1'b0, immR[31], 5'b0, immR[24:20], rs1I, f3, rdI, `OP_OP_IMM};
        end else begin
          word = {immR[31:20], rs1I, f3, rdI, `OP_OP_IMM};
        end
      end else if (kind == 5'd16) begin
        word = {immR[31:12], rdI, `OP_LUI};
      end else if (kind == 5'd17) begin
        word = {immR[31:12], rdI, `OP_AUIPC};
      end else if (kind < 5'd22) begin
        // 010 and 011 are no branches
        if (f3[2:1] == 2'b01) begin
          f3 = f3 ^ 3'b110;
        end
        bOff = {immR[12:2], 2'b00};
        word = {bOff[12], bOff[10:5], rs2I, rs1I, f3, bOff[4:1], bOff[11], `OP_BRANCH};
      end else if (kind == 5'd22) begin
        jOff = {immR[20:2], 2'b00};
        word = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rdI, `OP_JAL};
      end else if (kind == 5'd23) begin
        word = {immR[31:20], rs1I, 3'b000, rdI, `OP_JALR};
      end else if (kind < 5'd30) begin
        cmd = (immR[13:12] == 2'b00) ? 2'b10 : immR[13:12];
        word = {csrAddrOf(immR[3:2]), rs1I, 1'b0, cmd, rdI, `OP_SYSTEM};
      end else if (kind == 5'd30) begin
        word = {immR[31:25], rs2I, rs1I, 3'b010, immR[11:7], `OP_STORE};
      end else if (immR[1:0] == 2'b00) begin
        word = 32'h0000_0073;
      end else if (immR[1:0] == 2'b01) begin
        word = 32'h3020_0073;
      end else begin
        word = {immR[31:20], rs1I, 3'b000, rdI, `OP_OP_IMM};
      end
    end
  endtask

  task automatic modelStep(input logic [31:0] word, output rvcore_pkg::retireInfo exp);
    logic [2:0] f3;
    logic [4:0] rdI;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] old;
    logic [1:0] ci;
    logic taken;
    begin
      f3 = word[14:12];
      rdI = word[11:7];
      a = regs[word[19:15]];
      b = regs[word[24:20]];
      immI = {{20{word[31]}}, word[31:20]};
      immB = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      immJ = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      exp = '0;
      exp.valid = 1'b1;
      exp.pc = modelPc;
      exp.rd = rdI;
      exp.nextPc = modelPc + 32'd4;
      case (word[6:0])
        `OP_OP: begin
          exp.regWrite = 1'b1;
          exp.wbData = aluRef(f3, word[30], a, b);
        end
        `OP_OP_IMM: begin
          exp.regWrite = 1'b1;
          exp.wbData = aluRef(f3, word[30] && f3 == 3'b101, a, immI);
        end
        `OP_LUI: begin
          exp.regWrite = 1'b1;
          exp.wbData = {word[31:12], 12'b0};
        end
        `OP_AUIPC: begin
          exp.regWrite = 1'b1;
          exp.wbData = modelPc + {word[31:12], 12'b0};
        end
        `OP_BRANCH: begin
          case (f3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) begin
            exp.nextPc = modelPc + immB;
          end
        end
        `OP_JAL: begin
          exp.regWrite = 1'b1;
          exp.wbData = modelPc + 32'd4;
          exp.nextPc = modelPc + immJ;
        end
        `OP_JALR: begin
          exp.regWrite = 1'b1;
          exp.wbData = modelPc + 32'd4;
          exp.nextPc = (a + immI) & ~32'd1;
        end
        `OP_SYSTEM: begin
          if (f3 == 3'b000 && word[31:20] == 12'h000) begin
            exp.nextPc = csrs[0];
            csrs[1] = modelPc;
            csrs[2] = `CAUSE_ECALL;
          end else if (f3 == 3'b000) begin
            exp.nextPc = csrs[1];
          end else begin
            ci = csrIndex(word[31:20]);
            old = csrs[ci];
            exp.regWrite = 1'b1;
            exp.wbData = old;
            case (f3[1:0])
              2'b01: csrs[ci] = a;
              2'b10: csrs[ci] = old | a;
              default: csrs[ci] = old & ~a;
            endcase
          end
        end
        default: begin
          // stores retire as no-ops
        end
      endcase
      if (exp.regWrite && rdI != 5'd0) begin
        regs[rdI] = exp.wbData;
      end
      modelPc = exp.nextPc;
    end
  endtask

  task automatic checkPc(input string name, input logic [31:0] exp, input logic [31:0] act);
    begin
      checkCount++;
      if (act !== exp) begin
        errorCount++;
        $display("Mismatch %s: expected fetchPc %h, actual %h", name, exp, act);
      end
    end
  endtask

  // rd and wbData only matter when a register is written
  task automatic checkRetire(input string name, input rvcore_pkg::retireInfo exp,
                             input rvcore_pkg::retireInfo act);
    string expStr;
    string actStr;
    begin
      checkCount++;
      if (act.valid !== exp.valid || act.pc !== exp.pc || act.regWrite !== exp.regWrite ||
          act.nextPc !== exp.nextPc ||
          (exp.regWrite && (act.rd !== exp.rd || act.wbData !== exp.wbData))) begin
        errorCount++;
        expStr = $sformatf("pc %h rd %0d we %b wb %h next %h",
                           exp.pc, exp.rd, exp.regWrite, exp.wbData, exp.nextPc);
        actStr = $sformatf("pc %h rd %0d we %b wb %h next %h",
                           act.pc, act.rd, act.regWrite, act.wbData, act.nextPc);
        $display("Mismatch %s: expected %s, actual %s", name, expStr, actStr);
      end
    end
  endtask

  task automatic waitFetchReq(output int cycles, output bit found);
    begin
      cycles = 0;
      @(negedge clk);
      while (!fetchReq && cycles < Timeout) begin
        @(negedge clk);
        cycles++;
      end
      found = fetchReq;
      if (!found) begin
        errorCount++;
        $display("Timeout: no fetch request within %0d cycles", Timeout);
      end
    end
  endtask

  task automatic waitRetire(output int cycles, output bit found);
    begin
      cycles = 1;
      while (!retire.valid && cycles < Timeout) begin
        @(negedge clk);
        cycles++;
      end
      found = retire.valid;
      if (!found) begin
        errorCount++;
        $display("Timeout: no retire within %0d cycles of the answer", Timeout);
      end
    end
  endtask

  initial begin
    seed = 32'h3698de4d;
    reset = 1'b1;
    instValid = 1'b0;
    inst = '0;
    ok = 1'b1;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      csrs[i] = '0;
    end
    modelPc = `RESET_PC;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    for (n = 0; n < NumInsts && ok; n++) begin
      waitFetchReq(waited, ok);
      if (ok) begin
        if (waited != 0) begin
          errorCount++;
          $display("Fetch request %0d came %0d cycles late", n, waited);
        end
        makeInst(instWord);
        rnd = $random(seed);
        delay = rnd[1:0];
        repeat (delay) @(negedge clk);
        // fetchPc must hold while the answer is late
        checkPc($sformatf("fetch %0d", n), modelPc, fetchPc);
        instValid = 1'b1;
        inst = instWord;
        @(negedge clk);
        instValid = 1'b0;
        inst = '0;
        waitRetire(latency, ok);
      end
      if (ok) begin
        if (latency != 1) begin
          errorCount++;
          $display("Retire %0d came %0d cycles after the answer", n, latency);
        end
        if (fetchReq) begin
          errorCount++;
          $display("Fetch request raised in the retire cycle of instruction %0d", n);
        end
        modelStep(instWord, expRetire);
        checkRetire($sformatf("retire %0d", n), expRetire, retire);
      end
    end

    if (ok) begin
      waitFetchReq(waited, ok);
      if (ok) begin
        checkPc("final fetch", modelPc, fetchPc);
      end
    end
    @(posedge clk);
    if (ok && (retireCount != NumInsts || reqCount != NumInsts + 1)) begin
      errorCount++;
      $display("Expected %0d retires and %0d requests, saw %0d and %0d",
               NumInsts, NumInsts + 1, retireCount, reqCount);
    end

    $display("checks %0d, errors %0d, retired %0d, requests %0d",
             checkCount, errorCount, retireCount, reqCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/rvCore_props.sv ====
`timescale 1ns/1ps

module rvCore_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  fetchReq,
  input logic                  instValid,
  input rvcore_pkg::retireInfo retire
);
  // open after the request cycle until the answer
  logic reqOpen;
  logic accepted;

  assign accepted = instValid && (fetchReq || reqOpen);

  always_ff @(posedge clk) begin
    if (reset) begin
      reqOpen <= 1'b0;
    end else begin
      reqOpen <= (fetchReq || reqOpen) && !instValid;
    end
  end

  reqPulse: assert property (@(posedge clk) disable iff (reset) fetchReq |=> !fetchReq)
    else $error("fetchReq high for more than one cycle");

  retireAfterAnswer: assert property (@(posedge clk) disable iff (reset)
    accepted |=> retire.valid)
    else $error("retire.valid missing one cycle after an accepted instValid");

  noReqWhileOpen: assert property (@(posedge clk) disable iff (reset) reqOpen |-> !fetchReq)
    else $error("fetchReq raised while a request is open");

endmodule

bind rvCore rvCore_props i_props (
  .clk      (clk),
  .reset    (reset),
  .fetchReq (fetchReq),
  .instValid(instValid),
  .retire   (retire)
);

// ==== logic/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  instValid,
  input  logic [31:0]           inst,
  output logic                  fetchReq,
  output logic [31:0]           fetchPc,
  output rvcore_pkg::retireInfo retire
);
  rvcore_pkg::fetchPacket packet;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  logic regWrite;
  logic [31:0] wbData;
  logic [31:0] regData1;
  logic [31:0] regData2;
  logic [11:0] csrAddr;
  logic csrWrite;
  logic [31:0] csrWdata;
  logic [31:0] csrRdata;
  logic ecall;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] nextPc;

  rvFetch i_fetch (
    .clk      (clk),
    .reset    (reset),
    .instValid(instValid),
    .inst     (inst),
    .nextPc   (nextPc),
    .fetchReq (fetchReq),
    .fetchPc  (fetchPc),
    .packet   (packet)
  );

  // mret only redirects the PC
  rvExecute i_execute (
    .packet  (packet),
    .regData1(regData1),
    .regData2(regData2),
    .csrRdata(csrRdata),
    .mtvec   (mtvec),
    .mepc    (mepc),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .regWrite(regWrite),
    .wbData  (wbData),
    .csrAddr (csrAddr),
    .csrWrite(csrWrite),
    .csrWdata(csrWdata),
    .ecall   (ecall),
    .mret    (),
    .nextPc  (nextPc),
    .retire  (retire)
  );

  rvRegFile i_regFile (
    .clk     (clk),
    .reset   (reset),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .regWrite(regWrite),
    .wbData  (wbData),
    .regData1(regData1),
    .regData2(regData2)
  );

  rvCsrFile i_csrFile (
    .clk     (clk),
    .reset   (reset),
    .csrAddr (csrAddr),
    .csrWrite(csrWrite),
    .csrWdata(csrWdata),
    .ecall   (ecall),
    .pc      (packet.pc),
    .csrRdata(csrRdata),
    .mtvec   (mtvec),
    .mepc    (mepc)
  );

endmodule

// ==== logic/rvCsrFile.sv ====
`timescale 1ns/1ps
`include "rvcore_consts.svh"

module rvCsrFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [11:0] csrAddr,
  input  logic        csrWrite,
  input  logic [31:0] csrWdata,
  input  logic        ecall,
  input  logic [31:0] pc,
  output logic [31:0] csrRdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);
  logic [31:0] mcause;
  logic [31:0] mscratch;

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mscratch <= '0;
    end else if (ecall) begin
      mepc <= pc;
      mcause <= `CAUSE_ECALL;
    end else if (csrWrite) begin
      case (csrAddr)
        `CSR_MTVEC: mtvec <= csrWdata;
        `CSR_MEPC: mepc <= csrWdata;
        `CSR_MCAUSE: mcause <= csrWdata;
        `CSR_MSCRATCH: mscratch <= csrWdata;
        default: ;
      endcase
    end
  end

  // unknown addresses read zero
  always_comb begin
    case (csrAddr)
      `CSR_MTVEC: csrRdata = mtvec;
      `CSR_MEPC: csrRdata = mepc;
      `CSR_MCAUSE: csrRdata = mcause;
      `CSR_MSCRATCH: csrRdata = mscratch;
      default: csrRdata = 32'd0;
    endcase
  end

endmodule

// ==== logic/rvRegFile.sv ====
`timescale 1ns/1ps

module rvRegFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        regWrite,
  input  logic [31:0] wbData,
  output logic [31:0] regData1,
  output logic [31:0] regData2
);
  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && rd != 5'd0) begin
      regs[rd] <= wbData;
    end
  end

  // x0 hardwired
  assign regData1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign regData2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// ==== logic/rvExecute.sv ====
`timescale 1ns/1ps

module rvExecute (
  input  rvcore_pkg::fetchPacket packet,
  input  logic [31:0]            regData1,
  input  logic [31:0]            regData2,
  input  logic [31:0]            csrRdata,
  input  logic [31:0]            mtvec,
  input  logic [31:0]            mepc,
  output logic [4:0]             rs1,
  output logic [4:0]             rs2,
  output logic [4:0]             rd,
  output logic                   regWrite,
  output logic [31:0]            wbData,
  output logic [11:0]            csrAddr,
  output logic                   csrWrite,
  output logic [31:0]            csrWdata,
  output logic                   ecall,
  output logic                   mret,
  output logic [31:0]            nextPc,
  output rvcore_pkg::retireInfo  retire
);
  rvcore_pkg::ctrlWord ctrl;
  logic [31:0] imm;
  logic [31:0] aluA;
  logic [31:0] aluB;
  logic [31:0] aluOut;
  logic [31:0] snpc;
  logic brEq;
  logic brLt;
  logic brCond;
  logic brTaken;

  rvDecoder i_decoder (
    .inst(packet.inst),
    .ctrl(ctrl),
    .imm (imm)
  );

  assign rs1 = packet.inst[19:15];
  assign rs2 = packet.inst[24:20];
  assign rd = packet.inst[11:7];
  assign csrAddr = packet.inst[31:20];
  assign snpc = packet.pc + 32'd4;

  assign aluA = ctrl.aSelPc ? packet.pc : regData1;
  assign aluB = ctrl.bSelImm ? imm : regData2;

  always_comb begin
    case (ctrl.aluCtl)
      rvcore_pkg::aluSub: aluOut = aluA - aluB;
      rvcore_pkg::aluSll: aluOut = aluA << aluB[4:0];
      rvcore_pkg::aluSlt: aluOut = {31'b0, $signed(aluA) < $signed(aluB)};
      rvcore_pkg::aluSltu: aluOut = {31'b0, aluA < aluB};
      rvcore_pkg::aluXor: aluOut = aluA ^ aluB;
      rvcore_pkg::aluSrl: aluOut = aluA >> aluB[4:0];
      rvcore_pkg::aluSra: aluOut = $signed(aluA) >>> aluB[4:0];
      rvcore_pkg::aluOr: aluOut = aluA | aluB;
      rvcore_pkg::aluAnd: aluOut = aluA & aluB;
      rvcore_pkg::aluPassB: aluOut = aluB;
      default: aluOut = aluA + aluB;
    endcase
  end

  // funct3[1] picks unsigned compare, funct3[0] inverts
  assign brEq = (regData1 == regData2);
  assign brLt = ctrl.brFunct[1] ? (regData1 < regData2)
                                : ($signed(regData1) < $signed(regData2));
  assign brCond = ctrl.brFunct[2] ? brLt : brEq;
  assign brTaken = ctrl.branch && (brCond ^ ctrl.brFunct[0]);

  always_comb begin
    case (ctrl.csrCmd)
      2'b10: csrWdata = csrRdata | regData1;
      2'b11: csrWdata = csrRdata & ~regData1;
      default: csrWdata = regData1;
    endcase
  end

  always_comb begin
    case (ctrl.wbSrc)
      rvcore_pkg::wbSnpc: wbData = snpc;
      rvcore_pkg::wbCsr: wbData = csrRdata;
      default: wbData = aluOut;
    endcase
  end

  assign regWrite = packet.valid && ctrl.regWrite;
  assign csrWrite = packet.valid && ctrl.csrEn;
  assign ecall = packet.valid && ctrl.ecall;
  assign mret = packet.valid && ctrl.mret;

  // branch and jal targets come out of the alu as pc + imm
  always_comb begin
    if (mret) begin
      nextPc = mepc;
    end else if (ecall) begin
      nextPc = mtvec;
    end else if (brTaken || ctrl.jump) begin
      nextPc = aluOut;
    end else if (ctrl.jumpReg) begin
      nextPc = {aluOut[31:1], 1'b0};
    end else begin
      nextPc = snpc;
    end
  end

  always_comb begin
    retire.valid = packet.valid;
    retire.pc = packet.pc;
    retire.rd = rd;
    retire.regWrite = regWrite;
    retire.wbData = wbData;
    retire.nextPc = nextPc;
  end

endmodule

// ==== logic/rvDecoder.sv ====
`timescale 1ns/1ps
`include "rvcore_consts.svh"

module rvDecoder (
  input  logic [31:0]         inst,
  output rvcore_pkg::ctrlWord ctrl,
  output logic [31:0]         imm
);
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altFunct;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [31:0] immB;
  logic [31:0] immU;
  logic [31:0] immJ;
  rvcore_pkg::aluOp arithOp;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign altFunct = inst[30];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      `OP_STORE: imm = immS;
      `OP_BRANCH: imm = immB;
      `OP_LUI, `OP_AUIPC: imm = immU;
      `OP_JAL: imm = immJ;
      default: imm = immI;
    endcase
  end

  // sub only exists as a register op, sra in both forms
  always_comb begin
    case (funct3)
      3'b000: begin
        if (opcode == `OP_OP && altFunct) begin
          arithOp = rvcore_pkg::aluSub;
        end else begin
          arithOp = rvcore_pkg::aluAdd;
        end
      end
      3'b001: arithOp = rvcore_pkg::aluSll;
      3'b010: arithOp = rvcore_pkg::aluSlt;
      3'b011: arithOp = rvcore_pkg::aluSltu;
      3'b100: arithOp = rvcore_pkg::aluXor;
      3'b101: arithOp = altFunct ? rvcore_pkg::aluSra : rvcore_pkg::aluSrl;
      3'b110: arithOp = rvcore_pkg::aluOr;
      default: arithOp = rvcore_pkg::aluAnd;
    endcase
  end

  // all zero is add with alu writeback and nothing written
  always_comb begin
    ctrl = '0;
    case (opcode)
      `OP_OP: begin
        ctrl.aluCtl = arithOp;
        ctrl.regWrite = 1'b1;
      end
      `OP_OP_IMM: begin
        ctrl.aluCtl = arithOp;
        ctrl.bSelImm = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_LUI: begin
        ctrl.aluCtl = rvcore_pkg::aluPassB;
        ctrl.bSelImm = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_AUIPC: begin
        ctrl.aSelPc = 1'b1;
        ctrl.bSelImm = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      `OP_BRANCH: begin
        ctrl.aSelPc = 1'b1;
        ctrl.bSelImm = 1'b1;
        // funct3 010 and 011 are not branches
        if (funct3[2:1] != 2'b01) begin
          ctrl.branch = 1'b1;
          ctrl.brFunct = funct3;
        end
      end
      `OP_JAL: begin
        ctrl.aSelPc = 1'b1;
        ctrl.bSelImm = 1'b1;
        ctrl.jump = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSrc = rvcore_pkg::wbSnpc;
      end
      `OP_JALR: begin
        ctrl.bSelImm = 1'b1;
        ctrl.jumpReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSrc = rvcore_pkg::wbSnpc;
      end
      `OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ctrl.ecall = (inst[31:20] == 12'h000);
          ctrl.mret = (inst[31:20] == 12'h302);
        end else if (!funct3[2]) begin
          ctrl.csrEn = 1'b1;
          ctrl.csrCmd = funct3[1:0];
          ctrl.regWrite = 1'b1;
          ctrl.wbSrc = rvcore_pkg::wbCsr;
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== logic/rvFetch.sv ====
`timescale 1ns/1ps
`include "rvcore_consts.svh"

module rvFetch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instValid,
  input  logic [31:0]            inst,
  input  logic [31:0]            nextPc,
  output logic                   fetchReq,
  output logic [31:0]            fetchPc,
  output rvcore_pkg::fetchPacket packet
);
  // set with the request, cleared when its instruction arrives
  logic waiting;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchPc <= `RESET_PC;
      fetchReq <= 1'b0;
      waiting <= 1'b0;
      packet.valid <= 1'b0;
    end else begin
      fetchReq <= 1'b0;
      packet.valid <= 1'b0;
      // packet retires this cycle
      if (packet.valid) begin
        fetchPc <= nextPc;
      end
      if (!waiting) begin
        fetchReq <= 1'b1;
        waiting <= 1'b1;
      end else if (instValid) begin
        waiting <= 1'b0;
        packet.valid <= 1'b1;
        packet.pc <= fetchPc;
        packet.inst <= inst;
      end
    end
  end

endmodule

// ==== logic/rvcore_pkg.sv ====
`include "rvcore_consts.svh"

package rvcore_pkg;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
  } fetchPacket;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOp;

  typedef enum logic [1:0] {
    wbAlu,
    wbSnpc,
    wbCsr
  } wbSel;

  // csrCmd follows funct3[1:0], 01 write, 10 set, 11 clear
  typedef struct packed {
    aluOp       aluCtl;
    logic       aSelPc;
    logic       bSelImm;
    wbSel       wbSrc;
    logic       regWrite;
    logic       csrEn;
    logic [1:0] csrCmd;
    logic       branch;
    logic [2:0] brFunct;
    logic       jump;
    logic       jumpReg;
    logic       ecall;
    logic       mret;
  } ctrlWord;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    logic             regWrite;
    logic [`XLEN-1:0] wbData;
    logic [`XLEN-1:0] nextPc;
  } retireInfo;

endpackage

// ==== logic/rvcore_consts.svh ====
`ifndef RVCORE_CONSTS_SVH
`define RVCORE_CONSTS_SVH

`define XLEN 32
`define RESET_PC 32'h8000_0000

// base opcodes, inst[6:0]
`define OP_OP 7'b0110011
`define OP_OP_IMM 7'b0010011
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_BRANCH 7'b1100011
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111
`define OP_SYSTEM 7'b1110011
// stores retire as no-ops
`define OP_STORE 7'b0100011

// machine CSR addresses
`define CSR_MTVEC 12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`define CAUSE_ECALL 32'd11

`endif
